// File: compile.f
+incdir+logic
logic/pitch_pkg.sv
logic/peak_tracker.sv
logic/frame_energy.sv
logic/note_mapper.sv
logic/pitch_detector.sv
tests/pitch_detector_assert.sv
tests/pitch_detector_tb.sv

// File: Makefile
TOP := pitch_detector_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "All checks passed" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir $(LOG)

// File: tests/pitch_detector_tb.sv
`timescale 1ns/1ps
`include "pitch_config.svh"

module pitch_detector_tb;

    localparam int MAX_BINS    = 512;
    localparam int LONG_BINS   = 512;   // Room for peaks up to bin 511
    localparam int RAND_BINS   = 448;   // Covers low, in-band and out-of-table bins
    localparam int RAND_FRAMES = 30;
    localparam int DIR_FRAMES  = 11;
    localparam int RESULT_WAIT = 30;
    localparam int MAX_CYCLES  = DIR_FRAMES * (LONG_BINS + RESULT_WAIT)
                               + RAND_FRAMES * (RAND_BINS + RESULT_WAIT) + 500;

    logic                     clk_in;
    logic                     rst_in;
    logic                     sample_valid;
    pitch_pkg::bin_sample_t   sample;
    logic [`PITCH_SUM_W-1:0]  level_threshold;
    logic                     result_valid;
    pitch_pkg::pitch_result_t result;

    logic [`PITCH_MAG_W-1:0]  mags [MAX_BINS];   // Magnitudes of the frame being sent
    pitch_pkg::pitch_result_t results [$];
    int                       seed;
    int                       fail_count;
    int                       cycle_count;
    logic                     fail_reported;
    logic                     run_done;

    pitch_detector dut0 (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .sample_valid    (sample_valid),
        .sample          (sample),
        .level_threshold (level_threshold),
        .result_valid    (result_valid),
        .result          (result)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // Outputs are settled at the falling edge
    always @(negedge clk_in) begin
        if (!rst_in && result_valid) begin
            results.push_back(result);
        end
    end

    // ====================
    // Failure handling
    // ====================
    task automatic stop_with_failure();
        fail_count++;
        fail_reported = 1'b1;
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_result(input pitch_pkg::pitch_result_t got,
                                input pitch_pkg::pitch_result_t exp,
                                input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s", $time, what);
            $display("  got      found=%0b quiet=%0b note=%0d bin=%0d",
                     got.found, got.quiet, got.note, got.bin);
            $display("  expected found=%0b quiet=%0b note=%0d bin=%0d",
                     exp.found, exp.quiet, exp.note, exp.bin);
            stop_with_failure();
        end
    endtask

    task automatic check_valid_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    // ====================
    // Expected values
    // ====================
    function automatic pitch_pkg::pitch_result_t make_result(input int found, input int quiet,
                                                             input int note, input int bin);
        pitch_pkg::pitch_result_t r;
        r.found = found != 0;
        r.quiet = quiet != 0;
        r.note  = `PITCH_NOTE_W'(note);
        r.bin   = `PITCH_BIN_W'(bin);
        return r;
    endfunction

    function automatic pitch_pkg::pitch_result_t expected_result(
            input int nbins, input logic [`PITCH_SUM_W-1:0] thr);
        pitch_pkg::pitch_result_t r;
        int     best_bin;
        int     best_mag;
        int     i;
        int     k;
        longint total;
        longint sum_max;
        best_bin = 0;
        best_mag = int'(mags[0]);
        total    = longint'(mags[0]);
        sum_max  = (longint'(1) << `PITCH_SUM_W) - 1;
        for (i = 1; i < nbins; i++) begin
            total += longint'(mags[i]);
            if (int'(mags[i]) > best_mag) begin     // Lower index wins a tie
                best_mag = int'(mags[i]);
                best_bin = i;
            end
        end
        if (total > sum_max) total = sum_max;
        r = make_result(0, 0, 0, best_bin);
        if (total < longint'(thr)) begin
            r.quiet = 1'b1;
        end else if (best_bin >= `PITCH_MIN_BIN) begin
            for (k = 0; k < `PITCH_NOTE_COUNT && !r.found; k++) begin
                if (best_bin <= int'(pitch_pkg::NOTE_CEIL[k])) begin
                    r.found = 1'b1;
                    r.note  = `PITCH_NOTE_W'(k);
                end
            end
        end
        return r;
    endfunction

    // ====================
    // Stimulus
    // ====================
    task automatic fill_background(input int nbins);
        int i;
        for (i = 0; i < nbins; i++) begin
            mags[i] = `PITCH_MAG_W'((i * 37 + 11) % 97);   // Always below any peak
        end
    endtask

    task automatic stream_frame(input int nbins);
        int i;
        for (i = 0; i < nbins; i++) begin
            @(negedge clk_in);
            sample_valid = 1'b1;
            sample.mag   = mags[i];
            sample.last  = (i == nbins - 1);
        end
    endtask

    task automatic go_idle();
        @(negedge clk_in);
        sample_valid = 1'b0;
        sample       = '0;
    endtask

    task automatic wait_results(input int count);
        int waited;
        waited = 0;
        while (results.size() < count && waited < RESULT_WAIT) begin
            @(negedge clk_in);
            waited++;
        end
        if (results.size() < count) begin
            $display("Timeout at %0t ns: result_valid did not arrive within %0d cycles",
                     $time, RESULT_WAIT);
            stop_with_failure();
        end
    endtask

    task automatic run_frame(input int nbins, input logic [`PITCH_SUM_W-1:0] thr,
                             input pitch_pkg::pitch_result_t exp, input string what);
        pitch_pkg::pitch_result_t got;
        level_threshold = thr;
        stream_frame(nbins);
        go_idle();
        wait_results(1);
        got = results.pop_front();
        check_result(got, exp, what);
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_idle_after_reset();
        int i;
        for (i = 0; i < 20; i++) begin
            @(negedge clk_in);
            check_valid_flag(result_valid, 1'b0, "result_valid with no samples");
        end
    endtask

    task automatic test_in_band_notes();
        int peak_bins [5];
        int notes [5];
        int j;
        peak_bins = '{125, 131, 132, 300, 420};
        notes     = '{0, 0, 1, 15, 20};
        for (j = 0; j < 5; j++) begin
            fill_background(LONG_BINS);
            mags[peak_bins[j]] = 16'd1000;
            run_frame(LONG_BINS, '0, make_result(1, 0, notes[j], peak_bins[j]),
                      $sformatf("in-band peak at bin %0d", peak_bins[j]));
        end
    endtask

    task automatic test_out_of_band();
        fill_background(LONG_BINS);
        mags[100] = 16'd1000;
        run_frame(LONG_BINS, '0, make_result(0, 0, 0, 100), "peak below minimum bin");
        fill_background(LONG_BINS);
        mags[500] = 16'd1000;
        run_frame(LONG_BINS, '0, make_result(0, 0, 0, 500), "peak above last ceiling");
    endtask

    task automatic test_quiet_frame();
        fill_background(LONG_BINS);
        mags[200] = 16'd1000;
        run_frame(LONG_BINS, 24'hFF_FFFF, make_result(0, 1, 0, 200), "quiet frame");
    endtask

    task automatic test_ties_and_restart();
        pitch_pkg::pitch_result_t got;
        fill_background(LONG_BINS);
        mags[150] = 16'd2000;
        mags[200] = 16'd2000;
        run_frame(LONG_BINS, '0, make_result(1, 0, 3, 150), "tie between two maxima");
        // Second frame follows with no gap while the first search runs
        level_threshold = '0;
        fill_background(LONG_BINS);
        mags[300] = 16'd1000;
        stream_frame(LONG_BINS);
        fill_background(200);
        mags[130] = 16'd1000;
        stream_frame(200);
        go_idle();
        wait_results(2);
        got = results.pop_front();
        check_result(got, make_result(1, 0, 15, 300), "first of back-to-back frames");
        got = results.pop_front();
        check_result(got, make_result(1, 0, 0, 130), "second of back-to-back frames");
    endtask

    task automatic test_random_frames();
        pitch_pkg::pitch_result_t exp;
        logic [`PITCH_SUM_W-1:0]  thr;
        logic [31:0]              r;
        int                       f;
        int                       i;
        int                       pk;
        for (f = 0; f < RAND_FRAMES; f++) begin
            for (i = 0; i < RAND_BINS; i++) begin
                r       = $random(seed);
                mags[i] = {8'h00, r[7:0]};
            end
            r  = $random(seed);
            pk = int'(r[30:0]) % RAND_BINS;
            mags[pk] = {4'h1, r[11:0]};
            r  = $random(seed);
            if (r[1:0] == 2'b00) thr = 24'hFF_FFFF;    // Forced quiet
            else                 thr = {7'd0, r[16:0]}; // Straddles the frame sum
            exp = expected_result(RAND_BINS, thr);
            run_frame(RAND_BINS, thr, exp, $sformatf("random frame %0d, peak bin %0d", f, pk));
        end
    endtask

    // ====================
    // Run control
    // ====================
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
        fail_reported = 1'b1;
        $display("Checks failed");
        $fatal(1, "cycle limit reached");
    end

    initial begin
        rst_in          = 1'b1;
        sample_valid    = 1'b0;
        sample          = '0;
        level_threshold = '0;
        seed            = 6;
        fail_count      = 0;
        fail_reported   = 1'b0;
        run_done        = 1'b0;
        repeat (4) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;

        test_idle_after_reset();
        test_in_band_notes();
        test_out_of_band();
        test_quiet_frame();
        test_ties_and_restart();
        test_random_frames();

        run_done = 1'b1;
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            fail_reported = 1'b1;
            $display("Checks failed");
        end
        $finish;
    end

    // An assertion stop ends the run early
    final begin
        if (!run_done && !fail_reported) begin
            $display("Checks failed");
        end
    end

endmodule

// File: tests/pitch_detector_assert.sv
`timescale 1ns/1ps

module pitch_detector_assert (
    input wire clk_in,
    input wire rst_in,
    input wire result_valid,
    input wire peak_valid,
    input wire energy_valid,
    input wire busy
);

    // ====================
    // Result pulse
    // ====================
    a_result_single: assert property (
        @(posedge clk_in) disable iff (rst_in) result_valid |=> !result_valid
    ) else $error("result_valid stayed high for two cycles");

    // ====================
    // Frame analysis
    // ====================
    a_valid_aligned: assert property (
        @(posedge clk_in) disable iff (rst_in) peak_valid == energy_valid
    ) else $error("peak_valid and energy_valid are not aligned");

    // A frame shorter than the table walk lands here
    a_no_overlap: assert property (
        @(posedge clk_in) disable iff (rst_in) !(peak_valid && busy)
    ) else $error("peak_valid arrived while the note search was busy");

endmodule

bind pitch_detector pitch_detector_assert assert0 (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .result_valid (result_valid),
    .peak_valid   (peak_valid),
    .energy_valid (energy_valid),
    .busy         (mapper0.busy)
);

// File: logic/pitch_detector.sv
`timescale 1ns/1ps
`default_nettype none
`include "pitch_config.svh"

module pitch_detector (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      sample_valid,
    input  pitch_pkg::bin_sample_t   sample,
    input  wire [`PITCH_SUM_W-1:0]   level_threshold,
    output logic                     result_valid,
    output pitch_pkg::pitch_result_t result
);

    logic                 peak_valid;
    pitch_pkg::peak_t     peak;
    logic                 energy_valid;
    pitch_pkg::energy_t   energy;

    // ====================
    // Frame analysis
    // ====================
    peak_tracker peak0 (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample_valid (sample_valid),
        .sample       (sample),
        .peak_valid   (peak_valid),
        .peak         (peak)
    );

    frame_energy energy0 (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .sample_valid (sample_valid),
        .sample       (sample),
        .energy_valid (energy_valid),
        .energy       (energy)
    );

    // ====================
    // Note lookup
    // ====================
    note_mapper mapper0 (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .peak_valid      (peak_valid),
        .peak            (peak),
        .energy_valid    (energy_valid),
        .energy          (energy),
        .level_threshold (level_threshold),
        .result_valid    (result_valid),
        .result          (result)
    );

endmodule

`default_nettype wire

// File: logic/note_mapper.sv
`timescale 1ns/1ps
`default_nettype none
`include "pitch_config.svh"

module note_mapper (
    input  wire                      clk_in,
    input  wire                      rst_in,
    input  wire                      peak_valid,
    input  pitch_pkg::peak_t         peak,
    input  wire                      energy_valid,
    input  pitch_pkg::energy_t       energy,
    input  wire [`PITCH_SUM_W-1:0]   level_threshold,
    output logic                     result_valid,
    output pitch_pkg::pitch_result_t result
);

    logic                     busy;     // Table walk in progress
    logic [`PITCH_NOTE_W-1:0] idx;      // Table entry under test
    logic [`PITCH_BIN_W-1:0]  bin_q;

    logic frame_done;
    logic quiet;
    logic low_bin;
    logic hit;
    logic at_end;
    logic finish_now;
    logic finish_hit;
    logic finish_miss;

    // A new frame is taken only when idle
    assign frame_done  = peak_valid && energy_valid && !busy;
    assign quiet       = energy.sum < level_threshold;
    assign low_bin     = peak.bin < `PITCH_BIN_W'(`PITCH_MIN_BIN);
    assign finish_now  = frame_done && (quiet || low_bin);

    assign hit         = bin_q <= `PITCH_BIN_W'(pitch_pkg::NOTE_CEIL[idx]);
    assign at_end      = idx == `PITCH_NOTE_W'(`PITCH_NOTE_COUNT - 1);
    assign finish_hit  = busy && hit;
    assign finish_miss = busy && !hit && at_end;  // Table exhausted

    // ====================
    // Search control
    // ====================
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy         <= 1'b0;
            idx          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= finish_now || finish_hit || finish_miss;
            if (frame_done) begin
                idx  <= '0;
                busy <= !(quiet || low_bin);
            end else if (finish_hit || finish_miss) begin
                busy <= 1'b0;
            end else if (busy) begin
                idx <= idx + 1'b1;          // Next ceiling
            end
        end
    end

    // ====================
    // Result payload
    // ====================
    always_ff @(posedge clk_in) begin
        if (frame_done) begin
            bin_q      <= peak.bin;
            result.bin <= peak.bin;         // Bin is reported in every case
        end
        if (finish_now) begin
            result.found <= 1'b0;
            result.quiet <= quiet;
            result.note  <= '0;
        end else if (finish_hit) begin
            result.found <= 1'b1;
            result.quiet <= 1'b0;
            result.note  <= idx;
        end else if (finish_miss) begin
            result.found <= 1'b0;
            result.quiet <= 1'b0;
            result.note  <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/frame_energy.sv
`timescale 1ns/1ps
`default_nettype none
`include "pitch_config.svh"

module frame_energy (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    sample_valid,
    input  pitch_pkg::bin_sample_t sample,
    output logic                   energy_valid,
    output pitch_pkg::energy_t     energy
);

    logic [`PITCH_SUM_W-1:0] acc;
    logic [`PITCH_SUM_W:0]   sum_ext;   // One extra bit catches the carry
    logic [`PITCH_SUM_W-1:0] sum_sat;

    assign sum_ext = {1'b0, acc}
                   + {{(`PITCH_SUM_W - `PITCH_MAG_W + 1){1'b0}}, sample.mag};
    assign sum_sat = sum_ext[`PITCH_SUM_W] ? '1 : sum_ext[`PITCH_SUM_W-1:0];

    // ====================
    // Accumulator
    // ====================
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            acc          <= '0;
            energy_valid <= 1'b0;
        end else begin
            energy_valid <= 1'b0;
            if (sample_valid) begin
                if (sample.last) begin
                    acc          <= '0;     // Restart for the next frame
                    energy_valid <= 1'b1;
                end else begin
                    acc <= sum_sat;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (sample_valid && sample.last) begin
            energy.sum <= sum_sat;          // Sum with the final bin
        end
    end

endmodule

`default_nettype wire

// File: logic/peak_tracker.sv
`timescale 1ns/1ps
`default_nettype none
`include "pitch_config.svh"

module peak_tracker (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    sample_valid,
    input  pitch_pkg::bin_sample_t sample,
    output logic                   peak_valid,
    output pitch_pkg::peak_t       peak
);

    logic [`PITCH_BIN_W-1:0] bin_cnt;   // Index of the incoming bin
    logic [`PITCH_BIN_W-1:0] max_bin;
    logic [`PITCH_MAG_W-1:0] max_mag;

    logic                    take;
    logic [`PITCH_BIN_W-1:0] next_bin;
    logic [`PITCH_MAG_W-1:0] next_mag;

    // Strictly greater keeps the lower index on a tie
    assign take     = sample.mag > max_mag;
    assign next_bin = take ? bin_cnt : max_bin;
    assign next_mag = take ? sample.mag : max_mag;

    // ====================
    // Running maximum
    // ====================
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            bin_cnt    <= '0;
            max_bin    <= '0;
            max_mag    <= '0;
            peak_valid <= 1'b0;
        end else begin
            peak_valid <= 1'b0;
            if (sample_valid) begin
                if (sample.last) begin
                    bin_cnt    <= '0;       // Next frame starts at bin 0
                    max_bin    <= '0;
                    max_mag    <= '0;
                    peak_valid <= 1'b1;
                end else begin
                    bin_cnt <= bin_cnt + 1'b1;
                    max_bin <= next_bin;
                    max_mag <= next_mag;
                end
            end
        end
    end

    // ====================
    // Frame result
    // ====================
    always_ff @(posedge clk_in) begin
        if (sample_valid && sample.last) begin
            peak.bin <= next_bin;           // Includes the final bin
            peak.mag <= next_mag;
        end
    end

endmodule

`default_nettype wire

// File: logic/pitch_pkg.sv
`include "pitch_config.svh"

package pitch_pkg;

    // ====================
    // Stream and results
    // ====================
    typedef struct packed {
        logic [`PITCH_MAG_W-1:0] mag;
        logic                    last;  // Final bin of the frame
    } bin_sample_t;

    typedef struct packed {
        logic [`PITCH_BIN_W-1:0] bin;
        logic [`PITCH_MAG_W-1:0] mag;
    } peak_t;

    typedef struct packed {
        logic [`PITCH_SUM_W-1:0] sum;
    } energy_t;

    typedef struct packed {
        logic                     found;
        logic                     quiet;
        logic [`PITCH_NOTE_W-1:0] note;
        logic [`PITCH_BIN_W-1:0]  bin;
    } pitch_result_t;

    // Upper bin limit of each note, lowest note first
    localparam logic [9:0] NOTE_CEIL [`PITCH_NOTE_COUNT] = '{
        10'd131, 10'd139, 10'd147, 10'd156, 10'd166, 10'd176, 10'd186,
        10'd198, 10'd210, 10'd222, 10'd236, 10'd250, 10'd265, 10'd281,
        10'd297, 10'd315, 10'd333, 10'd354, 10'd374, 10'd398, 10'd420
    };

endpackage

// File: logic/pitch_config.svh
`ifndef PITCH_CONFIG_SVH
`define PITCH_CONFIG_SVH

// ====================
// Datapath widths
// ====================
`define PITCH_BIN_W       13  // Bin index
`define PITCH_MAG_W       16  // FFT magnitude
`define PITCH_SUM_W       24  // Frame energy, saturating
`define PITCH_NOTE_W      5   // Note number

// ====================
// Note table limits
// ====================
`define PITCH_NOTE_COUNT  21  // Entries in the ceiling table
`define PITCH_MIN_BIN     120 // Bins below this never map to a note

`endif
